// ==== Makefile ====
TOP := tb_cpu_backend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)
	verilator --lint-only -f flist.f --top-module cpu_backend

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== alu.sv ====
/* Execute stage ALU, purely combinational.
   Add and sub wrap, shifts are logical by one bit, and an unknown op code yields zero */

`default_nettype none
`timescale 1ns/100ps

`include "cpu_config.svh"

module alu
  import cpu_pkg::*;
(
  input  logic [`DATA_W-1:0] op_a,   // First operand
  input  logic [`DATA_W-1:0] op_b,   // Second operand
  input  alu_op_t            alu_op, // Operation select from decode
  output logic [`DATA_W-1:0] alu_out // Result to the EX/MEM register
);

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////
  always_comb begin
    unique case (alu_op)
      op_add:  alu_out = op_a + op_b; // Carry out is dropped
      op_sub:  alu_out = op_a - op_b; // Borrow is dropped
      op_and:  alu_out = op_a & op_b;
      op_or:   alu_out = op_a | op_b;
      op_xor:  alu_out = op_a ^ op_b;
      op_shl:  alu_out = {op_a[`DATA_W-2:0], 1'b0}; // Zero enters at the LSB
      op_shr:  alu_out = {1'b0, op_a[`DATA_W-1:1]}; // Zero enters at the MSB
      op_pass: alu_out = op_b;
      default: begin
        // Only reached with an X or Z code from an unset bundle
        alu_out = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== cpu_backend.sv ====
/* Execute, memory and write-back half of the 16-bit pipeline.
   One bundle is taken every cycle with no back-pressure, and its write-back appears two edges later.
   Decode must keep mem_read and mem_write exclusive and addresses inside the data memory */

`default_nettype none
`timescale 1ns/100ps

`include "cpu_config.svh"

module cpu_backend
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,    // Synchronous, active high
  input  id_ex_t   id_ex,  // Decoded bundle from the decode stage
  output wb_port_t wb,     // Register file write port
  output logic     halted  // Sticky halt status
);

  logic [`DATA_W-1:0] alu_out;
  ex_mem_t            ex_mem;
  logic [`DATA_W-1:0] load_data;

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  alu u_alu (
    .op_a    (id_ex.op_a),
    .op_b    (id_ex.op_b),
    .alu_op  (id_ex.alu_op),
    .alu_out (alu_out)
  );

  ex_mem_pipe_reg u_ex_mem (
    .clk      (clk),
    .rst      (rst),
    .pc_next  (id_ex.pc_next),
    .alu_out  (alu_out),
    .src_reg2 (id_ex.src_reg2),
    .mem_ctrl (id_ex.mem_ctrl),
    .wb_ctrl  (id_ex.wb_ctrl),
    .ex_mem   (ex_mem)
  );

  ////////////////////////////////////////
  // Memory and write-back
  ////////////////////////////////////////
  data_mem_stage u_dmem (
    .clk       (clk),
    .rst       (rst),
    .ex_mem    (ex_mem),
    .fwd       (wb), // WB result loops back for store forwarding
    .load_data (load_data)
  );

  mem_wb_stage u_mem_wb (
    .clk       (clk),
    .rst       (rst),
    .ex_mem    (ex_mem),
    .load_data (load_data),
    .wb        (wb),
    .halted    (halted)
  );

endmodule

`default_nettype wire

// ==== cpu_config.svh ====
/* Width settings shared by the whole back end.
   DMEM_AW sets the data memory depth at 2**DMEM_AW words, and it must stay below DATA_W */

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////
`define DATA_W   16 // Data word and PC width
`define REG_ID_W 4  // Register ID width for 16 architectural registers

////////////////////////////////////////
// Data memory
////////////////////////////////////////
`define DMEM_AW  8  // Word address bits, so 256 words of data memory

`endif

// ==== cpu_pkg.sv ====
/* Types for the EX, MEM and WB stage bundles.
   Field order in mem_ctrl_t and wb_ctrl_t keeps the 18-bit and 8-bit control word encodings */

`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

  ////////////////////////////////////////
  // ALU operation codes
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    op_add  = 3'd0, // Wraps on overflow
    op_sub  = 3'd1, // Wraps on underflow
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_shl  = 3'd5, // Logical shift left by one
    op_shr  = 3'd6, // Logical shift right by one
    op_pass = 3'd7  // Passes operand B straight through
  } alu_op_t;

  ////////////////////////////////////////
  // Control words
  ////////////////////////////////////////
  typedef struct packed {
    logic [`DATA_W-1:0] store_data; // Bits 17:2 of the memory control word
    logic               mem_read;   // Bit 1
    logic               mem_write;  // Bit 0
  } mem_ctrl_t;

  typedef struct packed {
    logic [`REG_ID_W-1:0] dest_reg; // Bits 7:4 of the write-back control word
    logic                 reg_write;
    logic                 mem_to_reg;
    logic                 pc_to_reg;
    logic                 halt;     // Bit 0
  } wb_ctrl_t;

  ////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////
  typedef struct packed {
    logic [`DATA_W-1:0]   pc_next;
    logic [`DATA_W-1:0]   op_a;
    logic [`DATA_W-1:0]   op_b;
    alu_op_t              alu_op;
    logic [`REG_ID_W-1:0] src_reg2; // Second source register, used for store forwarding
    mem_ctrl_t            mem_ctrl;
    wb_ctrl_t             wb_ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [`DATA_W-1:0]   pc_next;
    logic [`DATA_W-1:0]   alu_out;  // Result value and memory address both
    logic [`REG_ID_W-1:0] src_reg2;
    mem_ctrl_t            mem_ctrl;
    wb_ctrl_t             wb_ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic [`DATA_W-1:0] pc_next;
    logic [`DATA_W-1:0] alu_out;
    logic [`DATA_W-1:0] load_data;
    wb_ctrl_t           wb_ctrl;
  } mem_wb_t;

  typedef struct packed {
    logic                 wb_en;   // Register file write enable
    logic [`REG_ID_W-1:0] wb_reg;
    logic [`DATA_W-1:0]   wb_data;
  } wb_port_t;

endpackage

`default_nettype wire

// ==== data_mem_stage.sv ====
/* Memory stage with a 256 x 16 data memory, written on the clock and read combinationally.
   Only the low DMEM_AW bits of alu_out address the memory, and the upper bits must be zero.
   Store data is taken from the write-back port when the previous instruction wrote src_reg2 */

`default_nettype none
`timescale 1ns/100ps

`include "cpu_config.svh"

module data_mem_stage
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               rst,      // Blocks memory writes while high
  input  ex_mem_t            ex_mem,   // Instruction currently in MEM
  input  wb_port_t           fwd,      // Write-back port of the instruction now in WB
  output logic [`DATA_W-1:0] load_data // Word at the current address
);

  localparam int mem_depth = 1 << `DMEM_AW;

  logic [`DATA_W-1:0]  mem [mem_depth]; // Contents are undefined until stored
  logic [`DMEM_AW-1:0] addr;
  logic                fwd_hit;
  logic [`DATA_W-1:0]  store_word;

  assign addr = ex_mem.alu_out[`DMEM_AW-1:0]; // Word address, upper bits ignored

  ////////////////////////////////////////
  // Store data forwarding
  ////////////////////////////////////////
  // The register file has not been written yet when the previous result is still in WB,
  // so decode hands over a stale value for that register
  assign fwd_hit = ex_mem.mem_ctrl.mem_write && fwd.wb_en &&
                   (fwd.wb_reg == ex_mem.src_reg2);
  assign store_word = fwd_hit ? fwd.wb_data : ex_mem.mem_ctrl.store_data;

  ////////////////////////////////////////
  // Memory array
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst && ex_mem.mem_ctrl.mem_write) begin
      mem[addr] <= store_word; // Visible to a load from the next cycle on
    end
  end

  assign load_data = mem[addr]; // Asynchronous read, used only when mem_to_reg is set

  // Address aliasing would hide a decode or ALU fault, so flag it
  a_addr_in_range : assert property (@(posedge clk) disable iff (rst)
    (ex_mem.mem_ctrl.mem_read || ex_mem.mem_ctrl.mem_write) |->
      (ex_mem.alu_out[`DATA_W-1:`DMEM_AW] == '0))
    else $error("Data memory access above %0d words at 0x%h", mem_depth, ex_mem.alu_out);

endmodule

`default_nettype wire

// ==== ex_mem_pipe_reg.sv ====
/* EX/MEM stage register with no stall or flush.
   Synchronous reset clears every field, so the stage holds a bubble until the first bundle */

`default_nettype none
`timescale 1ns/100ps

`include "cpu_config.svh"

module ex_mem_pipe_reg
  import cpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,      // Synchronous, active high
  input  logic [`DATA_W-1:0]   pc_next,  // Next PC carried along for PC-to-register
  input  logic [`DATA_W-1:0]   alu_out,  // Execute result
  input  logic [`REG_ID_W-1:0] src_reg2, // Store data source register
  input  mem_ctrl_t            mem_ctrl, // Memory stage control word
  input  wb_ctrl_t             wb_ctrl,  // Write-back control word
  output ex_mem_t              ex_mem    // Register contents for the memory stage
);

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0; // All strobes low is a bubble
    end else begin
      ex_mem.pc_next  <= pc_next;
      ex_mem.alu_out  <= alu_out;
      ex_mem.src_reg2 <= src_reg2;
      ex_mem.mem_ctrl <= mem_ctrl;
      ex_mem.wb_ctrl  <= wb_ctrl;
    end
  end

  ////////////////////////////////////////
  // Control word checks
  ////////////////////////////////////////
  // A single port memory cannot load and store in the same cycle
  a_rw_exclusive : assert property (@(posedge clk) disable iff (rst)
    !(ex_mem.mem_ctrl.mem_read && ex_mem.mem_ctrl.mem_write))
    else $error("EX/MEM holds both mem_read and mem_write");

  // A load writing back must actually read memory, else WB picks up stale data
  a_load_reads : assert property (@(posedge clk) disable iff (rst)
    (ex_mem.wb_ctrl.reg_write && ex_mem.wb_ctrl.mem_to_reg) |-> ex_mem.mem_ctrl.mem_read)
    else $error("EX/MEM has mem_to_reg write-back without mem_read");

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
cpu_pkg.sv
alu.sv
ex_mem_pipe_reg.sv
data_mem_stage.sv
mem_wb_stage.sv
cpu_backend.sv
tb_cpu_backend.sv

// ==== mem_wb_stage.sv ====
/* MEM/WB stage register plus the write-back select.
   Select priority is PC-to-register, then load data, then the ALU result.
   The halted flag is sticky and only reset clears it */

`default_nettype none
`timescale 1ns/100ps

`include "cpu_config.svh"

module mem_wb_stage
  import cpu_pkg::*;
(
  input  logic               clk,
  input  logic               rst,       // Synchronous, active high
  input  ex_mem_t            ex_mem,    // Instruction leaving MEM
  input  logic [`DATA_W-1:0] load_data, // Memory read for that instruction
  output wb_port_t           wb,        // Register file write port
  output logic               halted     // Set once a halt reaches WB
);

  mem_wb_t mem_wb;

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb <= '0; // reg_write low so no write-back after reset
    end else begin
      mem_wb.pc_next   <= ex_mem.pc_next;
      mem_wb.alu_out   <= ex_mem.alu_out;
      mem_wb.load_data <= load_data;
      mem_wb.wb_ctrl   <= ex_mem.wb_ctrl;
    end
  end

  // Sticky halt, raised on the same edge that loads the halt instruction into WB
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (ex_mem.wb_ctrl.halt) begin
      halted <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Write-back select
  ////////////////////////////////////////
  always_comb begin
    wb.wb_en  = mem_wb.wb_ctrl.reg_write;
    wb.wb_reg = mem_wb.wb_ctrl.dest_reg;
    if (mem_wb.wb_ctrl.pc_to_reg) begin
      wb.wb_data = mem_wb.pc_next;   // Link value for calls
    end else if (mem_wb.wb_ctrl.mem_to_reg) begin
      wb.wb_data = mem_wb.load_data; // Load result
    end else begin
      wb.wb_data = mem_wb.alu_out;
    end
  end

endmodule

`default_nettype wire

// ==== tb_cpu_backend.sv ====
/* Testbench for the EX/MEM/WB back end. It acts as the decode stage and issues one bundle per cycle.
   It assumes 16-bit data and an 8-bit word address, and it fills the whole data memory first
   so that no load returns undefined data */

`default_nettype none
`timescale 1ns/100ps

`include "cpu_config.svh"

module tb_cpu_backend
  import cpu_pkg::*;
();

  localparam int n_fill = 1 << `DMEM_AW; // One store per memory word
  localparam int n_alu = 200;
  localparam int n_mem = 60;             // Store, load same, load other
  localparam int n_fwd = 12;             // Nine instructions per round
  localparam int n_sel = 20;             // Two instructions per round
  localparam int n_after_halt = 10;
  localparam int n_cycles = 4 + n_fill + n_alu + 3 * n_mem + 9 * n_fwd + 2 * n_sel + 1 +
                            n_after_halt + 3;

  logic     clk = 1'b0; // Starts low so no falling edge is seen at time zero
  logic     rst;
  id_ex_t   id_ex;
  wb_port_t wb;
  logic     halted;

  logic [`DATA_W-1:0] model_mem [1 << `DMEM_AW]; // Mirror of the data memory
  wb_port_t exp_wb [int];                        // Expected write-back, keyed by issue cycle
  string    exp_name [int];
  wb_port_t last_wb = '0;                        // Write-back of the previous issue
  int       cyc = 0;                             // Rising edges seen so far
  int       halt_cyc = 1 << 30;                  // Issue cycle of the first halt

  cpu_backend UUT (
    .clk    (clk),
    .rst    (rst),
    .id_ex  (id_ex),
    .wb     (wb),
    .halted (halted)
  );

  initial begin
    forever #20 clk = ~clk; // 40 ns period
  end

  ////////////////////////////////////////
  // Compare and timeout
  ////////////////////////////////////////
  task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopping at first error");
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > n_cycles + 20) begin
      $display("timeout: run went past %0d cycles without finishing", n_cycles + 20);
      $display("** FAIL **");
      $fatal(1, "stopping on timeout");
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Walks one bundle through EX, MEM and WB in issue order, so stores land before later loads
  function automatic wb_port_t expected_wb(id_ex_t b, wb_port_t prev);
    logic [`DATA_W-1:0] res;
    logic [`DATA_W-1:0] sdata;
    wb_port_t           r;
    case (b.alu_op)
      op_add:  res = b.op_a + b.op_b;
      op_sub:  res = b.op_a - b.op_b;
      op_and:  res = b.op_a & b.op_b;
      op_or:   res = b.op_a | b.op_b;
      op_xor:  res = b.op_a ^ b.op_b;
      op_shl:  res = b.op_a << 1;
      op_shr:  res = b.op_a >> 1;
      default: res = b.op_b; // Pass B
    endcase
    if (b.mem_ctrl.mem_write) begin
      // The previous instruction sits in WB while this one stores
      sdata = (prev.wb_en && prev.wb_reg == b.src_reg2) ? prev.wb_data : b.mem_ctrl.store_data;
      model_mem[res[`DMEM_AW-1:0]] = sdata;
    end
    r.wb_en  = b.wb_ctrl.reg_write;
    r.wb_reg = b.wb_ctrl.dest_reg;
    if (b.wb_ctrl.pc_to_reg) r.wb_data = b.pc_next;
    else if (b.wb_ctrl.mem_to_reg) r.wb_data = model_mem[res[`DMEM_AW-1:0]];
    else r.wb_data = res;
    return r;
  endfunction

  // Fires every falling edge and looks at the bundle issued two cycles back
  always @(negedge clk) begin : check_wb
    wb_port_t e;
    if (exp_wb.exists(cyc - 2)) begin
      e = exp_wb[cyc - 2];
      compare({exp_name[cyc - 2], " wb_en"}, 32'(e.wb_en), 32'(wb.wb_en));
      if (e.wb_en) begin // Register and data only matter when the port writes
        compare({exp_name[cyc - 2], " wb_reg"}, 32'(e.wb_reg), 32'(wb.wb_reg));
        compare({exp_name[cyc - 2], " wb_data"}, 32'(e.wb_data), 32'(wb.wb_data));
      end
    end
    if (cyc > 4) compare("halted", 32'(cyc - 2 >= halt_cyc), 32'(halted));
  end

  ////////////////////////////////////////
  // Bundle builders and issue
  ////////////////////////////////////////
  function automatic id_ex_t alu_instr(alu_op_t op, logic [15:0] a, logic [15:0] b,
                                       logic [3:0] dest);
    id_ex_t x;
    x = '0;
    x.pc_next = 16'($urandom);
    x.op_a = a;
    x.op_b = b;
    x.alu_op = op;
    x.mem_ctrl.store_data = 16'($urandom); // Ignored since no store
    x.wb_ctrl.dest_reg = dest;
    x.wb_ctrl.reg_write = 1'b1;
    return x;
  endfunction

  // Address goes through pass-B so the upper bits stay zero
  function automatic id_ex_t load_instr(logic [7:0] addr, logic [3:0] dest);
    id_ex_t x;
    x = alu_instr(op_pass, 16'($urandom), {8'h00, addr}, dest);
    x.mem_ctrl.mem_read = 1'b1;
    x.wb_ctrl.mem_to_reg = 1'b1;
    return x;
  endfunction

  function automatic id_ex_t store_instr(logic [7:0] addr, logic [15:0] data, logic [3:0] src2);
    id_ex_t x;
    x = alu_instr(op_pass, 16'($urandom), {8'h00, addr}, 4'h0);
    x.src_reg2 = src2;
    x.mem_ctrl.store_data = data;
    x.mem_ctrl.mem_write = 1'b1;
    x.wb_ctrl.reg_write = 1'b0;
    return x;
  endfunction

  task automatic issue(id_ex_t b, string name);
    @(negedge clk);
    id_ex = b;
    exp_wb[cyc] = expected_wb(b, last_wb);
    exp_name[cyc] = name;
    last_wb = exp_wb[cyc];
    if (b.wb_ctrl.halt && halt_cyc > cyc) halt_cyc = cyc;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    int         i;
    id_ex_t     b;
    logic [7:0] a;
    logic [3:0] r;
    void'($urandom(53));
    rst = 1'b1;
    id_ex = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    compare("reset wb_en", 0, 32'(wb.wb_en)); // Nothing issued yet
    compare("reset halted", 0, 32'(halted));

    for (i = 0; i < n_fill; i++) begin
      issue(store_instr(8'(i), {8'(i), ~8'(i)} ^ 16'h3c5a, 4'(i)), "fill");
    end
    for (i = 0; i < n_alu; i++) begin // Op codes cycle so every one is hit
      issue(alu_instr(alu_op_t'(3'(i)), 16'($urandom), 16'($urandom), 4'($urandom)), "alu");
    end
    for (i = 0; i < n_mem; i++) begin
      a = 8'($urandom);
      issue(store_instr(a, 16'($urandom), 4'($urandom)), "store");
      issue(load_instr(a, 4'($urandom)), "load same");
      issue(load_instr(a + 8'(1 + $urandom_range(254)), 4'($urandom)), "load other");
    end
    for (i = 0; i < n_fwd; i++) begin
      r = 4'($urandom);
      a = 8'($urandom);
      issue(alu_instr(op_pass, 16'h0, 16'($urandom), r), "fwd alu");
      issue(store_instr(a, 16'($urandom), r), "fwd alu store");
      issue(load_instr(a, 4'($urandom)), "fwd alu readback");
      issue(load_instr(8'($urandom), r), "fwd load");
      issue(store_instr(a, 16'($urandom), r), "fwd load store");
      issue(load_instr(a, 4'($urandom)), "fwd load readback");
      issue(alu_instr(op_add, 16'($urandom), 16'($urandom), r), "nofwd alu");
      issue(store_instr(a, 16'($urandom), r ^ 4'h1), "nofwd store"); // Register differs
      issue(load_instr(a, 4'($urandom)), "nofwd readback");
    end
    for (i = 0; i < n_sel; i++) begin
      b = load_instr(8'($urandom), 4'($urandom)); // PC select must win over the load data
      b.wb_ctrl.pc_to_reg = 1'b1;
      issue(b, "pc to reg");
      b = alu_instr(alu_op_t'(3'($urandom)), 16'($urandom), 16'($urandom), 4'($urandom));
      b.wb_ctrl.reg_write = 1'b0;
      issue(b, "no reg write");
    end

    b = alu_instr(op_add, 16'($urandom), 16'($urandom), 4'($urandom));
    b.wb_ctrl.halt = 1'b1;
    issue(b, "halt");
    for (i = 0; i < n_after_halt; i++) begin // Flag must hold while work continues
      issue(alu_instr(op_xor, 16'($urandom), 16'($urandom), 4'($urandom)), "after halt");
    end
    repeat (3) issue('0, "drain");
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
